//--- Makefile
# Verilator lint and simulation of the staging buffer
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= staging_top.f
TB_TOP    ?= tb_staging
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/100ps
PASS_TEXT ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

# lint the whole design through the testbench top
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_tasks.svh
// bus access, checking and model helpers for the staging testbench
// included inside the testbench module; uses its clock, bus signals and counters
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// single write, strobe high for one cycle
task automatic bus_write(input int addr, input logic [31:0] data);
    @(posedge clk);
    slave_address    <= addr[stage_pkg::csr_addr_width-1:0];
    slave_writedata  <= data;
    slave_write      <= 1'b1;
    slave_chipselect <= 1'b1;
    @(posedge clk);
    slave_write      <= 1'b0;
    slave_chipselect <= 1'b0;
endtask

// single read, data taken on the falling edge after the capture
task automatic bus_read(input int addr, output logic [31:0] data);
    @(posedge clk);
    slave_address    <= addr[stage_pkg::csr_addr_width-1:0];
    slave_read       <= 1'b1;
    slave_chipselect <= 1'b1;
    @(posedge clk);
    slave_read       <= 1'b0;
    slave_chipselect <= 1'b0;
    @(negedge clk);
    data = slave_readdata;
endtask

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
endtask

task automatic report_failure(input string what);
    error_count++;
    $display("Error: %s", what);
endtask

// read a CSR until the masked bits match, bounded by poll_limit
task automatic poll_csr(input int addr, input logic [31:0] mask,
                        input logic [31:0] expected, input string what);
    logic [31:0] value;
    int          reads;
    bus_read(addr, value);
    reads = 1;
    while (((value & mask) != expected) && (reads < poll_limit))
    begin
        bus_read(addr, value);
        reads++;
    end
    if ((value & mask) != expected)
    begin
        report_failure($sformatf("%s, gave up after %0d reads", what, reads));
    end
endtask

// load both halves, pulse push_req, wait for the fsm to go back to idle
task automatic push_word_to_buffer(input logic [63:0] word);
    logic [31:0] busy_mask;
    busy_mask = 32'h1 << stage_pkg::bit_push_busy;
    bus_write(stage_pkg::csr_push_lo, word[31:0]);
    bus_write(stage_pkg::csr_push_hi, word[63:32]);
    bus_write(stage_pkg::csr_push, 32'h1 << stage_pkg::bit_push_req);
    poll_csr(stage_pkg::csr_push, busy_mask, busy_mask, "push_busy never went high");
    bus_write(stage_pkg::csr_push, 32'h0);
    poll_csr(stage_pkg::csr_push, busy_mask, 32'h0, "push_busy never went low");
    model_queue.push_back(word);
endtask

// one pop, compared against the oldest word in the model
task automatic pop_and_compare();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] expected;
    logic [31:0] valid_mask;
    valid_mask = 32'h1 << stage_pkg::bit_pop_valid;
    bus_write(stage_pkg::csr_out_status, 32'h1 << stage_pkg::bit_pop_req);
    poll_csr(stage_pkg::csr_pop, valid_mask, valid_mask, "pop_valid never went high");
    // drop pop_req before the ack, or the fsm pops again
    bus_write(stage_pkg::csr_out_status, 32'h0);
    bus_read(stage_pkg::csr_pop_hi, hi);
    bus_read(stage_pkg::csr_pop_lo, lo);
    if (model_queue.size() == 0)
    begin
        report_failure("pop returned a word but the model queue is empty");
    end
    else
    begin
        expected = model_queue.pop_front();
        check_value("csr_pop_hi", 64'(expected[63:32]), 64'(hi));
        check_value("csr_pop_lo", 64'(expected[31:0]), 64'(lo));
    end
    bus_write(stage_pkg::csr_pop, 32'h1 << stage_pkg::bit_pop_ack);
    poll_csr(stage_pkg::csr_pop, valid_mask, 32'h0, "pop_valid stayed high after pop_ack");
endtask

task automatic begin_test();
    test_number++;
    errors_at_start = error_count;
endtask

// one line per finished test
task automatic end_test(input string name);
    if (error_count == errors_at_start)
    begin
        $display("test %0d (%s): ok", test_number, name);
    end
    else
    begin
        tests_failed++;
        $display("test %0d (%s): %0d error(s)", test_number, name,
                 error_count - errors_at_start);
    end
endtask

`endif

//--- bench/tb_staging.sv
// testbench for staging_top with a queue model of the pushed words
// random data from $urandom with a fixed seed; strobes driven on the rising edge
// readdata sampled on the falling edge; a watchdog bounds the run
`timescale 1ns/100ps

module tb_staging;

    localparam int push_words      = 12;
    localparam int test_total      = 6;
    localparam int poll_limit      = 60;
    localparam int watchdog_cycles = 400 * test_total + 40 * push_words;

    logic                                 clk;
    logic                                 reset_n;
    logic [stage_pkg::csr_addr_width-1:0] slave_address;
    logic [stage_pkg::csr_data_width-1:0] slave_writedata;
    logic                                 slave_write;
    logic                                 slave_read;
    logic                                 slave_chipselect;
    logic [stage_pkg::csr_data_width-1:0] slave_readdata;

    // bookkeeping
    int error_count;
    int check_count;
    int tests_failed;
    int test_number;
    int errors_at_start;
    int alias_index;
    int alias_addr;

    // model and scratch storage
    logic [63:0] model_queue [$];
    logic [31:0] scratch_model [1:34];
    logic [31:0] rd_data;
    logic [63:0] word;

    `include "tb_tasks.svh"

    staging_top dut0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .slave_address    (slave_address),
        .slave_writedata  (slave_writedata),
        .slave_write      (slave_write),
        .slave_read       (slave_read),
        .slave_chipselect (slave_chipselect),
        .slave_readdata   (slave_readdata)
    );

    // 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // budget scales with tests and pushed words
    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, a test stalled", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(51462));
        error_count      = 0;
        check_count      = 0;
        tests_failed     = 0;
        test_number      = 0;
        errors_at_start  = 0;
        reset_n          = 1'b0;
        slave_address    = '0;
        slave_writedata  = '0;
        slave_write      = 1'b0;
        slave_read       = 1'b0;
        slave_chipselect = 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // counters at base, buffer empty, no fsm flags
        begin_test();
        bus_read(stage_pkg::csr_in_count, rd_data);
        check_value("csr_in_count", 64'(stage_pkg::buffer_base), 64'(rd_data));
        bus_read(stage_pkg::csr_out_count, rd_data);
        check_value("csr_out_count", 64'(stage_pkg::buffer_base), 64'(rd_data));
        bus_read(stage_pkg::csr_out_status, rd_data);
        check_value("csr_out_status", 64'(32'h1 << stage_pkg::bit_out_empty), 64'(rd_data));
        bus_read(stage_pkg::csr_push, rd_data);
        check_value("csr_push", 64'h0, 64'(rd_data));
        bus_read(stage_pkg::csr_pop, rd_data);
        check_value("csr_pop", 64'h0, 64'(rd_data));
        end_test("reset state");

        // plain registers 1 to 34
        begin_test();
        for (int i = 1; i <= 34; i++)
        begin
            scratch_model[i] = $urandom();
            bus_write(i, scratch_model[i]);
        end
        for (int i = 1; i <= 34; i++)
        begin
            bus_read(i, rd_data);
            check_value($sformatf("csr_%0d", i), 64'(scratch_model[i]), 64'(rd_data));
        end
        // out-of-range writes that alias onto scratch indices
        for (int i = 0; i < 8; i++)
        begin
            alias_index = 1 + int'($urandom() % 34);
            alias_addr  = stage_pkg::csr_count * (1 + int'($urandom() % 3)) + alias_index;
            bus_write(alias_addr, $urandom());
        end
        for (int i = 1; i <= 34; i++)
        begin
            bus_read(i, rd_data);
            check_value($sformatf("csr_%0d", i), 64'(scratch_model[i]), 64'(rd_data));
        end
        end_test("scratch registers");

        begin_test();
        for (int i = 0; i < push_words; i++)
        begin
            word = {$urandom(), $urandom()};
            push_word_to_buffer(word);
        end
        bus_read(stage_pkg::csr_in_count, rd_data);
        check_value("csr_in_count", 64'(stage_pkg::buffer_base) + 64'(push_words), 64'(rd_data));
        end_test("push");

        // drain copies the input RAM top-down into the output RAM
        begin_test();
        bus_write(stage_pkg::csr_control, 32'h1 << stage_pkg::bit_drain_enable);
        poll_csr(stage_pkg::csr_in_count, 32'hffff_ffff, 32'(stage_pkg::buffer_base),
                 "csr_in_count never drained to buffer_base");
        repeat (4)
        begin
            bus_read(stage_pkg::csr_in_count, rd_data);
            check_value("csr_in_count", 64'(stage_pkg::buffer_base), 64'(rd_data));
        end
        bus_read(stage_pkg::csr_out_count, rd_data);
        check_value("csr_out_count", 64'(stage_pkg::buffer_base) + 64'(push_words),
                    64'(rd_data));
        bus_read(stage_pkg::csr_out_status, rd_data);
        check_value("out_empty", 64'h0, 64'(rd_data[stage_pkg::bit_out_empty]));
        bus_write(stage_pkg::csr_control, 32'h0);
        end_test("drain");

        begin_test();
        repeat (push_words) pop_and_compare();
        bus_read(stage_pkg::csr_out_status, rd_data);
        check_value("out_empty", 64'h1, 64'(rd_data[stage_pkg::bit_out_empty]));
        end_test("pop in order");

        // request on an empty buffer must be ignored
        begin_test();
        bus_write(stage_pkg::csr_out_status, 32'h1 << stage_pkg::bit_pop_req);
        repeat (20)
        begin
            bus_read(stage_pkg::csr_pop, rd_data);
            check_value("pop_valid", 64'h0, 64'(rd_data[stage_pkg::bit_pop_valid]));
        end
        bus_read(stage_pkg::csr_out_count, rd_data);
        check_value("csr_out_count", 64'(stage_pkg::buffer_base), 64'(rd_data));
        bus_write(stage_pkg::csr_out_status, 32'h0);
        end_test("pop while empty");

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 test_number, tests_failed, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/addr_counters.sv
// input and output RAM address counters
// drain decrement beats a push increment in the same cycle
// out_we increment beats pop_start; host must not pop during a drain
`timescale 1ns/100ps

module addr_counters (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 push_done,
    input  logic                                 pop_start,
    input  logic                                 drain_enable,
    input  logic                                 out_we,
    output logic [stage_pkg::ram_addr_width-1:0] in_addr,
    output logic [stage_pkg::ram_addr_width-1:0] out_addr,
    output logic                                 out_empty,
    output logic                                 drain_re
);

    logic drain_step;

    // one drain read per cycle while words remain
    assign drain_step = drain_enable && (in_addr > stage_pkg::buffer_base);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            in_addr  <= stage_pkg::buffer_base;
            out_addr <= stage_pkg::buffer_base;
            drain_re <= 1'b0;
        end
        else
        begin
            // strobe lines up with the already decremented address
            drain_re <= drain_step;

            if (drain_step)
            begin
                in_addr <= in_addr - 1'b1;
            end
            else if (push_done)
            begin
                in_addr <= in_addr + 1'b1;
            end

            // step past each word written by the drain pipe
            if (out_we)
            begin
                out_addr <= out_addr + 1'b1;
            end
            else if (pop_start)
            begin
                out_addr <= out_addr - 1'b1;
            end
        end
    end

    assign out_empty = (out_addr == stage_pkg::buffer_base);

endmodule

//--- src/csr_bank.sv
// 64 x 32-bit CSR bank behind the bus slave port
// fixed one-cycle read latency with no wait states
// a bus write beats any hardware status update to the same register
// a write and a read in the same cycle perform only the write
`timescale 1ns/100ps

module csr_bank (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic [stage_pkg::csr_addr_width-1:0]  slave_address,
    input  logic [stage_pkg::csr_data_width-1:0]  slave_writedata,
    input  logic                                  slave_write,
    input  logic                                  slave_read,
    input  logic                                  slave_chipselect,
    output logic [stage_pkg::csr_data_width-1:0]  slave_readdata,
    input  logic                                  push_busy,
    input  logic                                  pop_valid,
    input  stage_pkg::stage_word_u                pop_word,
    input  logic [stage_pkg::ram_addr_width-1:0]  in_addr,
    input  logic [stage_pkg::ram_addr_width-1:0]  out_addr,
    input  logic                                  out_empty,
    output logic                                  push_req,
    output logic                                  pop_req,
    output logic                                  pop_ack,
    output logic                                  drain_enable,
    output stage_pkg::stage_word_u                push_word
);

    // register file
    logic [stage_pkg::csr_count-1:0][stage_pkg::csr_data_width-1:0] csr_regs;

    // low address bits pick the register and addr_valid screens the rest
    logic [$clog2(stage_pkg::csr_count)-1:0] csr_index;
    logic                                    addr_valid;
    logic                                    fsm_idle;

    assign csr_index  = slave_address[$clog2(stage_pkg::csr_count)-1:0];
    assign addr_valid =
        (slave_address < stage_pkg::csr_addr_width'(stage_pkg::csr_count));
    // neither push nor pop flag means the fsm sits in idle
    assign fsm_idle   = !push_busy && !pop_valid;

    // command bits out to the control logic
    assign push_req     = csr_regs[stage_pkg::csr_push][stage_pkg::bit_push_req];
    assign pop_req      = csr_regs[stage_pkg::csr_out_status][stage_pkg::bit_pop_req];
    assign pop_ack      = csr_regs[stage_pkg::csr_pop][stage_pkg::bit_pop_ack];
    assign drain_enable = csr_regs[stage_pkg::csr_control][stage_pkg::bit_drain_enable];

    // push word built from the two halves
    always_comb
    begin
        push_word.half.hi = csr_regs[stage_pkg::csr_push_hi];
        push_word.half.lo = csr_regs[stage_pkg::csr_push_lo];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr_regs       <= '0;
            slave_readdata <= '0;
        end
        else
        begin
            // status mirrors refreshed every cycle
            csr_regs[stage_pkg::csr_push][stage_pkg::bit_push_busy]        <= push_busy;
            csr_regs[stage_pkg::csr_pop][stage_pkg::bit_pop_valid]         <= pop_valid;
            csr_regs[stage_pkg::csr_out_status][stage_pkg::bit_out_empty]  <= out_empty;

            // ack only lives until the fsm is back in idle
            if (fsm_idle)
            begin
                csr_regs[stage_pkg::csr_pop][stage_pkg::bit_pop_ack] <= 1'b0;
            end

            // recapture the output RAM word for the whole pop state
            if (pop_valid)
            begin
                csr_regs[stage_pkg::csr_pop_hi] <= pop_word.half.hi;
                csr_regs[stage_pkg::csr_pop_lo] <= pop_word.half.lo;
            end

            // debug view of both address counters
            csr_regs[stage_pkg::csr_in_count] <=
                {{(stage_pkg::csr_data_width - stage_pkg::ram_addr_width){1'b0}}, in_addr};
            csr_regs[stage_pkg::csr_out_count] <=
                {{(stage_pkg::csr_data_width - stage_pkg::ram_addr_width){1'b0}}, out_addr};

            // bus access last, so a write overrides the updates above
            if (slave_write && slave_chipselect && addr_valid)
            begin
                csr_regs[csr_index] <= slave_writedata;
            end
            else if (slave_read && slave_chipselect && addr_valid)
            begin
                slave_readdata <= csr_regs[csr_index];
            end
        end
    end

endmodule

//--- src/drain_pipe.sv
// drain read pipeline from input RAM q to output RAM write
// out_we follows each drain_re by exactly three cycles
// no back-pressure; up to three reads in flight
`timescale 1ns/100ps

module drain_pipe (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   drain_re,
    input  stage_pkg::stage_word_u in_q,
    output logic                   out_we,
    output stage_pkg::stage_word_u out_data
);

    // flag 1: RAM q valid, flag 2: word held in q_hold
    logic                   read_flag_1;
    logic                   read_flag_2;
    logic                   write_next;
    stage_pkg::stage_word_u q_hold;

    assign write_next = read_flag_2;

    // strobe delay flags
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_flag_1 <= 1'b0;
            read_flag_2 <= 1'b0;
            out_we      <= 1'b0;
        end
        else
        begin
            read_flag_1 <= drain_re;
            read_flag_2 <= read_flag_1;
            out_we      <= write_next;
        end
    end

    // payload follows its flag, so back-to-back reads keep their own word
    always_ff @(posedge clk)
    begin
        if (read_flag_1)
        begin
            q_hold <= in_q;
        end
        if (write_next)
        begin
            out_data <= q_hold;
        end
    end

endmodule

//--- src/stage_fsm.sv
// idle, push and pop control for the two word RAMs
// push has priority over pop in idle; pop needs a non-empty output RAM
// in_we and out_re are registered, push_done and pop_start are combinational
`timescale 1ns/100ps

module stage_fsm (
    input  logic clk,
    input  logic reset_n,
    input  logic push_req,
    input  logic pop_req,
    input  logic pop_ack,
    input  logic out_empty,
    output logic push_busy,
    output logic pop_valid,
    output logic in_we,
    output logic out_re,
    output logic push_done,
    output logic pop_start
);

    enum logic [1:0] {st_idle, st_push, st_pop} state, state_next;

    // next state and counter events
    always_comb
    begin
        state_next = state;
        push_done  = 1'b0;
        pop_start  = 1'b0;
        case (state)
            st_idle:
            begin
                if (push_req)
                begin
                    state_next = st_push;
                end
                else if (pop_req && !out_empty)
                begin
                    // counter steps down to the last written word
                    state_next = st_pop;
                    pop_start  = 1'b1;
                end
            end
            st_push:
            begin
                // host drops push_req to finish the push
                if (!push_req)
                begin
                    state_next = st_idle;
                    push_done  = 1'b1;
                end
            end
            st_pop:
            begin
                if (pop_ack)
                begin
                    state_next = st_idle;
                end
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state  <= st_idle;
            in_we  <= 1'b0;
            out_re <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            // single write pulse on entry to push
            in_we  <= (state == st_idle) && push_req;
            // read held for the whole pop state
            out_re <= (state_next == st_pop);
        end
    end

    assign push_busy = (state == st_push);
    assign pop_valid = (state == st_pop);

endmodule

//--- src/stage_pkg.sv
// shared widths, CSR map and word type for the staging buffer
// CSR map covers 64 registers; slave addresses at 64 and above are ignored
// both RAM counters reset to buffer_base, so address 0 is never used
package stage_pkg;

    // bus and CSR bank sizes
    localparam int csr_addr_width = 8;
    localparam int csr_data_width = 32;
    localparam int csr_count      = 64;

    // word RAM geometry
    localparam int ram_addr_width = 14;
    localparam int word_width     = 64;

    // first usable RAM address, also the empty level of both counters
    localparam logic [ram_addr_width-1:0] buffer_base = ram_addr_width'(1);

    // CSR indices
    localparam int csr_control    = 0;
    localparam int csr_push       = 35;
    localparam int csr_push_lo    = 36;
    localparam int csr_push_hi    = 37;
    localparam int csr_pop        = 38;
    localparam int csr_pop_lo     = 39;
    localparam int csr_pop_hi     = 40;
    localparam int csr_out_status = 45;
    localparam int csr_in_count   = 50;
    localparam int csr_out_count  = 51;

    // bit positions inside those CSRs
    localparam int bit_drain_enable = 2;
    localparam int bit_push_req     = 0;
    localparam int bit_push_busy    = 31;
    localparam int bit_pop_valid    = 0;
    localparam int bit_pop_ack      = 31;
    localparam int bit_out_empty    = 0;
    localparam int bit_pop_req      = 31;

    // one RAM word, or the two CSR halves that carry it
    typedef struct packed {
        logic [csr_data_width-1:0] hi;
        logic [csr_data_width-1:0] lo;
    } stage_halves_t;

    typedef union packed {
        logic [word_width-1:0] word;
        stage_halves_t         half;
    } stage_word_u;

endpackage

//--- src/staging_top.sv
// staging buffer top: CSR bank, control, two word RAMs, drain pipe
// words come back in push order after drain and pop reverse them twice
// host must not push during a drain
`timescale 1ns/100ps

module staging_top (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic [stage_pkg::csr_addr_width-1:0] slave_address,
    input  logic [stage_pkg::csr_data_width-1:0] slave_writedata,
    input  logic                                 slave_write,
    input  logic                                 slave_read,
    input  logic                                 slave_chipselect,
    output logic [stage_pkg::csr_data_width-1:0] slave_readdata
);

    // bank commands
    logic                   push_req;
    logic                   pop_req;
    logic                   pop_ack;
    logic                   drain_enable;
    stage_pkg::stage_word_u push_word;

    // fsm strobes and events
    logic push_busy;
    logic pop_valid;
    logic in_we;
    logic out_re;
    logic push_done;
    logic pop_start;

    // counters and RAM data
    logic [stage_pkg::ram_addr_width-1:0] in_addr;
    logic [stage_pkg::ram_addr_width-1:0] out_addr;
    logic                                 out_empty;
    logic                                 drain_re;
    logic                                 out_we;
    stage_pkg::stage_word_u               in_q;
    stage_pkg::stage_word_u               out_data;
    stage_pkg::stage_word_u               pop_word;

    csr_bank csr_bank0 (
        .clk              (clk),
        .reset_n          (reset_n),
        .slave_address    (slave_address),
        .slave_writedata  (slave_writedata),
        .slave_write      (slave_write),
        .slave_read       (slave_read),
        .slave_chipselect (slave_chipselect),
        .slave_readdata   (slave_readdata),
        .push_busy        (push_busy),
        .pop_valid        (pop_valid),
        .pop_word         (pop_word),
        .in_addr          (in_addr),
        .out_addr         (out_addr),
        .out_empty        (out_empty),
        .push_req         (push_req),
        .pop_req          (pop_req),
        .pop_ack          (pop_ack),
        .drain_enable     (drain_enable),
        .push_word        (push_word)
    );

    stage_fsm stage_fsm0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .push_req  (push_req),
        .pop_req   (pop_req),
        .pop_ack   (pop_ack),
        .out_empty (out_empty),
        .push_busy (push_busy),
        .pop_valid (pop_valid),
        .in_we     (in_we),
        .out_re    (out_re),
        .push_done (push_done),
        .pop_start (pop_start)
    );

    addr_counters addr_counters0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .push_done    (push_done),
        .pop_start    (pop_start),
        .drain_enable (drain_enable),
        .out_we       (out_we),
        .in_addr      (in_addr),
        .out_addr     (out_addr),
        .out_empty    (out_empty),
        .drain_re     (drain_re)
    );

    // in_addr serves both push writes and drain reads
    word_ram in_ram (
        .clk   (clk),
        .addr  (in_addr),
        .we    (in_we),
        .re    (drain_re),
        .wdata (push_word),
        .q     (in_q)
    );

    // out_addr serves both drain writes and pop reads
    word_ram out_ram (
        .clk   (clk),
        .addr  (out_addr),
        .we    (out_we),
        .re    (out_re),
        .wdata (out_data),
        .q     (pop_word)
    );

    drain_pipe drain_pipe0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .drain_re (drain_re),
        .in_q     (in_q),
        .out_we   (out_we),
        .out_data (out_data)
    );

endmodule

//--- src/word_ram.sv
// single-port 16K x 64 word RAM, registered read
// q holds its value while re is low; contents are not reset
// read and write in one cycle returns the old word
`timescale 1ns/100ps

module word_ram (
    input  logic                                 clk,
    input  logic [stage_pkg::ram_addr_width-1:0] addr,
    input  logic                                 we,
    input  logic                                 re,
    input  stage_pkg::stage_word_u               wdata,
    output stage_pkg::stage_word_u               q
);

    logic [stage_pkg::word_width-1:0] mem [2**stage_pkg::ram_addr_width];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata.word;
        end
        // read port
        if (re)
        begin
            q.word <= mem[addr];
        end
    end

endmodule

//--- staging_top.f
+incdir+bench
src/stage_pkg.sv
src/word_ram.sv
src/csr_bank.sv
src/stage_fsm.sv
src/addr_counters.sv
src/drain_pipe.sv
src/staging_top.sv
bench/tb_staging.sv
